// File: source/isa_pkg.sv
package isa_pkg;

        typedef logic [31:0] inst_t;
        typedef logic [6:0]  opcode_t;
        typedef logic [2:0]  funct3_t;
        typedef logic [6:0]  funct7_t;

        // major opcodes, inst[6:0]
        localparam opcode_t op_reg    = 7'b0110011;
        localparam opcode_t op_reg_w  = 7'b0111011;
        localparam opcode_t op_imm    = 7'b0010011;
        localparam opcode_t op_imm_w  = 7'b0011011;
        localparam opcode_t op_load   = 7'b0000011;
        localparam opcode_t op_store  = 7'b0100011;
        localparam opcode_t op_branch = 7'b1100011;
        localparam opcode_t op_jal    = 7'b1101111;
        localparam opcode_t op_jalr   = 7'b1100111;
        localparam opcode_t op_auipc  = 7'b0010111;
        localparam opcode_t op_lui    = 7'b0110111;
        localparam opcode_t op_system = 7'b1110011;

        // funct7, inst[31:25]
        localparam funct7_t f7_base = 7'b0000000;
        localparam funct7_t f7_alt  = 7'b0100000; // sub, sra and their w forms

        localparam inst_t inst_ebreak = 32'h0010_0073;

endpackage

// File: source/ctrl_pkg.sv
package ctrl_pkg;

        typedef logic [4:0] alu_sel_t;
        typedef logic [2:0] imm_sel_t;
        typedef logic [1:0] alu_a_sel_t;
        typedef logic       alu_b_sel_t;
        typedef logic [1:0] reg_w_sel_t;
        typedef logic [2:0] mem_r_sel_t;
        typedef logic [7:0] mem_mask_t;
        typedef logic       pc_sel_t;

        localparam alu_sel_t alu_add  = 5'd0;
        localparam alu_sel_t alu_sub  = 5'd1;
        localparam alu_sel_t alu_and  = 5'd2;
        localparam alu_sel_t alu_or   = 5'd3;
        localparam alu_sel_t alu_xor  = 5'd4;
        localparam alu_sel_t alu_sll  = 5'd5;
        localparam alu_sel_t alu_srl  = 5'd6;
        localparam alu_sel_t alu_sra  = 5'd7;
        localparam alu_sel_t alu_lt   = 5'd8;
        localparam alu_sel_t alu_ltu  = 5'd9;
        localparam alu_sel_t alu_addw = 5'd10; // w forms sign-extend bit 31
        localparam alu_sel_t alu_subw = 5'd11;
        localparam alu_sel_t alu_sllw = 5'd12;
        localparam alu_sel_t alu_srlw = 5'd13;
        localparam alu_sel_t alu_sraw = 5'd14;

        localparam imm_sel_t imm_i  = 3'd0;
        localparam imm_sel_t imm_s  = 3'd1;
        localparam imm_sel_t imm_sb = 3'd2;
        localparam imm_sel_t imm_u  = 3'd3;
        localparam imm_sel_t imm_uj = 3'd4;

        localparam alu_a_sel_t a_rs1  = 2'd0;
        localparam alu_a_sel_t a_pc   = 2'd1;
        localparam alu_a_sel_t a_zero = 2'd2;

        localparam alu_b_sel_t b_rs2 = 1'b0;
        localparam alu_b_sel_t b_imm = 1'b1;

        localparam reg_w_sel_t w_alu = 2'd0;
        localparam reg_w_sel_t w_mem = 2'd1;
        localparam reg_w_sel_t w_pc  = 2'd2; // link value pc + 4

        // same numbering as the load funct3
        localparam mem_r_sel_t r_b  = 3'd0;
        localparam mem_r_sel_t r_h  = 3'd1;
        localparam mem_r_sel_t r_w  = 3'd2;
        localparam mem_r_sel_t r_d  = 3'd3;
        localparam mem_r_sel_t r_bu = 3'd4;
        localparam mem_r_sel_t r_hu = 3'd5;
        localparam mem_r_sel_t r_wu = 3'd6;

        localparam mem_mask_t mask_b = 8'h01;
        localparam mem_mask_t mask_h = 8'h03;
        localparam mem_mask_t mask_w = 8'h0f;
        localparam mem_mask_t mask_d = 8'hff;

        localparam pc_sel_t pc_snpc = 1'b0;
        localparam pc_sel_t pc_alu  = 1'b1;

endpackage

// File: source/alu_decode.sv
`timescale 1ns/1ps

module alu_decode (
        input  isa_pkg::inst_t          inst,
        output logic                    hit,
        output ctrl_pkg::alu_sel_t      alu_sel,
        output ctrl_pkg::imm_sel_t      imm_sel,
        output ctrl_pkg::alu_a_sel_t    alu_a_sel,
        output ctrl_pkg::alu_b_sel_t    alu_b_sel
);

        isa_pkg::opcode_t opcode;
        isa_pkg::funct3_t funct3;
        isa_pkg::funct7_t funct7;
        ctrl_pkg::alu_sel_t op;

        assign opcode = inst[6:0];
        assign funct3 = inst[14:12];
        assign funct7 = inst[31:25];

        always_comb begin
                hit = 1'b0;
                op  = ctrl_pkg::alu_add;
                case (opcode)
                isa_pkg::op_reg: begin
                        hit = 1'b1;
                        case ({funct7, funct3})
                        {isa_pkg::f7_base, 3'b000}: op = ctrl_pkg::alu_add;
                        {isa_pkg::f7_alt,  3'b000}: op = ctrl_pkg::alu_sub;
                        {isa_pkg::f7_base, 3'b001}: op = ctrl_pkg::alu_sll;
                        {isa_pkg::f7_base, 3'b010}: op = ctrl_pkg::alu_lt;
                        {isa_pkg::f7_base, 3'b011}: op = ctrl_pkg::alu_ltu;
                        {isa_pkg::f7_base, 3'b100}: op = ctrl_pkg::alu_xor;
                        {isa_pkg::f7_base, 3'b101}: op = ctrl_pkg::alu_srl;
                        {isa_pkg::f7_alt,  3'b101}: op = ctrl_pkg::alu_sra;
                        {isa_pkg::f7_base, 3'b110}: op = ctrl_pkg::alu_or;
                        {isa_pkg::f7_base, 3'b111}: op = ctrl_pkg::alu_and;
                        default: hit = 1'b0; // incl. M extension
                        endcase
                end
                isa_pkg::op_reg_w: begin
                        hit = 1'b1;
                        case ({funct7, funct3})
                        {isa_pkg::f7_base, 3'b000}: op = ctrl_pkg::alu_addw;
                        {isa_pkg::f7_alt,  3'b000}: op = ctrl_pkg::alu_subw;
                        {isa_pkg::f7_base, 3'b001}: op = ctrl_pkg::alu_sllw;
                        {isa_pkg::f7_base, 3'b101}: op = ctrl_pkg::alu_srlw;
                        {isa_pkg::f7_alt,  3'b101}: op = ctrl_pkg::alu_sraw;
                        default: hit = 1'b0;
                        endcase
                end
                isa_pkg::op_imm: begin
                        hit = 1'b1;
                        case (funct3)
                        3'b000: op = ctrl_pkg::alu_add;
                        3'b010: op = ctrl_pkg::alu_lt;
                        3'b011: op = ctrl_pkg::alu_ltu;
                        3'b100: op = ctrl_pkg::alu_xor;
                        3'b110: op = ctrl_pkg::alu_or;
                        3'b111: op = ctrl_pkg::alu_and;
                        3'b001: begin // inst[25] is shamt[5]
                                op  = ctrl_pkg::alu_sll;
                                hit = funct7[6:1] == isa_pkg::f7_base[6:1];
                        end
                        default: begin
                                if (funct7[6:1] == isa_pkg::f7_base[6:1])
                                        op = ctrl_pkg::alu_srl;
                                else if (funct7[6:1] == isa_pkg::f7_alt[6:1])
                                        op = ctrl_pkg::alu_sra;
                                else
                                        hit = 1'b0;
                        end
                        endcase
                end
                isa_pkg::op_imm_w: begin
                        hit = 1'b1;
                        case ({funct7, funct3})
                        {isa_pkg::f7_base, 3'b001}: op = ctrl_pkg::alu_sllw;
                        {isa_pkg::f7_base, 3'b101}: op = ctrl_pkg::alu_srlw;
                        {isa_pkg::f7_alt,  3'b101}: op = ctrl_pkg::alu_sraw;
                        default: begin
                                op  = ctrl_pkg::alu_addw;
                                hit = funct3 == 3'b000; // addiw, any imm
                        end
                        endcase
                end
                isa_pkg::op_auipc, isa_pkg::op_lui: hit = 1'b1;
                default: hit = 1'b0;
                endcase
        end

        always_comb begin
                alu_sel   = ctrl_pkg::alu_add;
                imm_sel   = ctrl_pkg::imm_i;
                alu_a_sel = ctrl_pkg::a_rs1;
                alu_b_sel = ctrl_pkg::b_rs2;
                if (hit) begin
                        alu_sel = op;
                        if (opcode != isa_pkg::op_reg && opcode != isa_pkg::op_reg_w)
                                alu_b_sel = ctrl_pkg::b_imm;
                        if (opcode == isa_pkg::op_auipc) begin
                                imm_sel   = ctrl_pkg::imm_u;
                                alu_a_sel = ctrl_pkg::a_pc;
                        end else if (opcode == isa_pkg::op_lui) begin
                                imm_sel   = ctrl_pkg::imm_u;
                                alu_a_sel = ctrl_pkg::a_zero; // 0 + imm
                        end
                end
        end

endmodule

// File: source/mem_decode.sv
`timescale 1ns/1ps

module mem_decode (
        input  isa_pkg::inst_t          inst,
        output logic                    hit,
        output logic                    mem_ren,
        output logic                    mem_wen,
        output ctrl_pkg::mem_mask_t     mem_mask,
        output ctrl_pkg::mem_r_sel_t    mem_r_sel,
        output ctrl_pkg::imm_sel_t      imm_sel
);

        isa_pkg::opcode_t opcode;
        isa_pkg::funct3_t funct3;

        assign opcode = inst[6:0];
        assign funct3 = inst[14:12];

        // address is rs1 + imm, the all-zero alu defaults
        always_comb begin
                mem_ren   = 1'b0;
                mem_wen   = 1'b0;
                mem_mask  = 8'h00;
                mem_r_sel = ctrl_pkg::r_b;
                imm_sel   = ctrl_pkg::imm_i;
                if (opcode == isa_pkg::op_load && funct3 != 3'b111) begin
                        mem_ren   = 1'b1;
                        mem_r_sel = ctrl_pkg::mem_r_sel_t'(funct3); // lb .. lwu
                end
                if (opcode == isa_pkg::op_store && !funct3[2]) begin
                        mem_wen = 1'b1;
                        imm_sel = ctrl_pkg::imm_s;
                        case (funct3[1:0])
                        2'b00:   mem_mask = ctrl_pkg::mask_b;
                        2'b01:   mem_mask = ctrl_pkg::mask_h;
                        2'b10:   mem_mask = ctrl_pkg::mask_w;
                        default: mem_mask = ctrl_pkg::mask_d;
                        endcase
                end
        end

        assign hit = mem_ren | mem_wen;

endmodule

// File: source/flow_decode.sv
`timescale 1ns/1ps

module flow_decode (
        input  isa_pkg::inst_t          inst,
        input  logic                    b_eq,
        input  logic                    b_lt,
        input  logic                    b_ltu,
        output logic                    hit,
        output logic                    is_ebreak,
        output ctrl_pkg::pc_sel_t       pc_sel,
        output ctrl_pkg::imm_sel_t      imm_sel,
        output ctrl_pkg::alu_a_sel_t    alu_a_sel,
        output logic                    link
);

        isa_pkg::opcode_t opcode;
        isa_pkg::funct3_t funct3;
        logic taken;

        assign opcode = inst[6:0];
        assign funct3 = inst[14:12];

        always_comb begin
                case (funct3)
                3'b000:  taken = b_eq;
                3'b001:  taken = !b_eq;
                3'b100:  taken = b_lt;
                3'b101:  taken = !b_lt;
                3'b110:  taken = b_ltu;
                default: taken = !b_ltu;
                endcase
        end

        always_comb begin
                hit       = 1'b0;
                is_ebreak = 1'b0;
                pc_sel    = ctrl_pkg::pc_snpc;
                imm_sel   = ctrl_pkg::imm_i;
                alu_a_sel = ctrl_pkg::a_rs1;
                link      = 1'b0;
                case (opcode)
                isa_pkg::op_branch: begin
                        if (funct3[2:1] != 2'b01) begin // 010, 011 reserved
                                hit       = 1'b1;
                                imm_sel   = ctrl_pkg::imm_sb;
                                alu_a_sel = ctrl_pkg::a_pc;
                                pc_sel    = taken ? ctrl_pkg::pc_alu : ctrl_pkg::pc_snpc;
                        end
                end
                isa_pkg::op_jal: begin
                        hit       = 1'b1;
                        link      = 1'b1;
                        imm_sel   = ctrl_pkg::imm_uj;
                        alu_a_sel = ctrl_pkg::a_pc;
                        pc_sel    = ctrl_pkg::pc_alu;
                end
                isa_pkg::op_jalr: begin
                        hit    = funct3 == 3'b000; // rs1 + imm_i
                        link   = hit;
                        pc_sel = hit ? ctrl_pkg::pc_alu : ctrl_pkg::pc_snpc;
                end
                isa_pkg::op_system: begin
                        is_ebreak = inst == isa_pkg::inst_ebreak;
                        hit       = is_ebreak; // ecall and csr ops not decoded
                end
                default: hit = 1'b0;
                endcase
        end

endmodule

// File: source/control.sv
`timescale 1ns/1ps

module control (
        input  logic                    clk,
        input  logic                    arst_n,
        input  isa_pkg::inst_t          inst,
        input  logic                    b_eq,
        input  logic                    b_lt,
        input  logic                    b_ltu,
        output ctrl_pkg::pc_sel_t       pc_sel,
        output logic                    ebreak_flag,
        output ctrl_pkg::imm_sel_t      imm_sel,
        output ctrl_pkg::alu_sel_t      alu_sel,
        output ctrl_pkg::alu_a_sel_t    alu_a_sel,
        output ctrl_pkg::alu_b_sel_t    alu_b_sel,
        output ctrl_pkg::mem_r_sel_t    mem_r_sel,
        output logic                    reg_wen,
        output logic                    mem_wen,
        output logic                    mem_ren,
        output ctrl_pkg::mem_mask_t     mem_mask,
        output ctrl_pkg::reg_w_sel_t    reg_w_sel
);

        logic alu_hit, mem_hit, flow_hit;
        logic mem_ren_d, mem_wen_d, is_ebreak, link;
        ctrl_pkg::alu_sel_t     alu_sel_d;
        ctrl_pkg::imm_sel_t     alu_imm, mem_imm, flow_imm;
        ctrl_pkg::alu_a_sel_t   alu_a_alu, alu_a_flow;
        ctrl_pkg::alu_b_sel_t   alu_b_alu, alu_b_d;
        ctrl_pkg::mem_mask_t    mem_mask_d;
        ctrl_pkg::mem_r_sel_t   mem_r_sel_d;
        ctrl_pkg::pc_sel_t      pc_sel_d;
        ctrl_pkg::reg_w_sel_t   reg_w_sel_d;
        logic ebreak_d, reg_wen_d;

        alu_decode u_alu_decode (
                .inst(inst), .hit(alu_hit), .alu_sel(alu_sel_d),
                .imm_sel(alu_imm), .alu_a_sel(alu_a_alu), .alu_b_sel(alu_b_alu)
        );

        mem_decode u_mem_decode (
                .inst(inst), .hit(mem_hit), .mem_ren(mem_ren_d), .mem_wen(mem_wen_d),
                .mem_mask(mem_mask_d), .mem_r_sel(mem_r_sel_d), .imm_sel(mem_imm)
        );

        flow_decode u_flow_decode (
                .inst(inst), .b_eq(b_eq), .b_lt(b_lt), .b_ltu(b_ltu),
                .hit(flow_hit), .is_ebreak(is_ebreak), .pc_sel(pc_sel_d),
                .imm_sel(flow_imm), .alu_a_sel(alu_a_flow), .link(link)
        );

        // decoders give zeros on a miss, so an illegal word leaves every enable low
        assign ebreak_d  = is_ebreak | !(alu_hit | mem_hit | flow_hit);
        assign reg_wen_d = alu_hit | mem_ren_d | link;
        assign alu_b_d   = alu_b_alu | ((mem_hit | (flow_hit & !is_ebreak)) ?
                           ctrl_pkg::b_imm : ctrl_pkg::b_rs2);

        always_comb begin
                reg_w_sel_d = ctrl_pkg::w_alu;
                if (mem_ren_d)
                        reg_w_sel_d = ctrl_pkg::w_mem;
                else if (link)
                        reg_w_sel_d = ctrl_pkg::w_pc;
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        pc_sel      <= ctrl_pkg::pc_snpc;
                        ebreak_flag <= 1'b0;
                        imm_sel     <= ctrl_pkg::imm_i;
                        alu_sel     <= ctrl_pkg::alu_add;
                        alu_a_sel   <= ctrl_pkg::a_rs1;
                        alu_b_sel   <= ctrl_pkg::b_rs2;
                        mem_r_sel   <= ctrl_pkg::r_b;
                        reg_wen     <= 1'b0;
                        mem_wen     <= 1'b0;
                        mem_ren     <= 1'b0;
                        mem_mask    <= 8'h00;
                        reg_w_sel   <= ctrl_pkg::w_alu;
                end else begin
                        pc_sel      <= pc_sel_d;
                        ebreak_flag <= ebreak_d;
                        imm_sel     <= alu_imm | mem_imm | flow_imm;
                        alu_sel     <= alu_sel_d;
                        alu_a_sel   <= alu_a_alu | alu_a_flow;
                        alu_b_sel   <= alu_b_d;
                        mem_r_sel   <= mem_r_sel_d;
                        reg_wen     <= reg_wen_d;
                        mem_wen     <= mem_wen_d;
                        mem_ren     <= mem_ren_d;
                        mem_mask    <= mem_mask_d;
                        reg_w_sel   <= reg_w_sel_d;
                end
        end

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
        output logic clk
);

        localparam time half_period = 20ns; // 40 ns clock

        initial begin
                clk = 1'b0;
                forever #(half_period) clk = ~clk;
        end

endmodule

// File: sim/control_props.sv
`timescale 1ns/1ps

module control_props (
        input logic clk,
        input logic arst_n,
        input logic alu_hit,
        input logic mem_hit,
        input logic flow_hit,
        input logic mem_wen,
        input logic mem_ren,
        input logic reg_wen,
        input logic ebreak_flag,
        input logic pc_sel
);

        a_mem_excl: assert property (@(posedge clk) disable iff (!arst_n)
                !(mem_wen && mem_ren))
                else $error("mem_wen and mem_ren high together");

        a_one_hit: assert property (@(posedge clk) disable iff (!arst_n)
                $onehot0({alu_hit, mem_hit, flow_hit}))
                else $error("more than one decoder hit");

        // registered outputs sit at zero through reset
        a_reset_zero: assert property (@(posedge clk)
                !arst_n |-> !(reg_wen || mem_wen || mem_ren || ebreak_flag || pc_sel))
                else $error("output active during reset");

endmodule

bind control control_props u_control_props (
        .clk(clk), .arst_n(arst_n), .alu_hit(alu_hit), .mem_hit(mem_hit),
        .flow_hit(flow_hit), .mem_wen(mem_wen), .mem_ren(mem_ren),
        .reg_wen(reg_wen), .ebreak_flag(ebreak_flag), .pc_sel(pc_sel)
);

// File: sim/control_tb.sv
`timescale 1ns/1ps

module control_tb;

        localparam int num_inst  = 3000;
        localparam int rst_cyc   = 8;
        localparam int max_cycle = 3200; // reset plus run plus margin

        typedef struct packed {
                ctrl_pkg::pc_sel_t      pc;
                logic                   ebreak;
                ctrl_pkg::imm_sel_t     imm;
                ctrl_pkg::alu_sel_t     alu;
                ctrl_pkg::alu_a_sel_t   a;
                ctrl_pkg::alu_b_sel_t   b;
                ctrl_pkg::mem_r_sel_t   r;
                logic                   reg_wen;
                logic                   mem_wen;
                logic                   mem_ren;
                ctrl_pkg::mem_mask_t    mask;
                ctrl_pkg::reg_w_sel_t   w;
        } exp_t;

        logic clk, arst_n, b_eq, b_lt, b_ltu;
        isa_pkg::inst_t inst;
        ctrl_pkg::pc_sel_t pc_sel;
        ctrl_pkg::imm_sel_t imm_sel;
        ctrl_pkg::alu_sel_t alu_sel;
        ctrl_pkg::alu_a_sel_t alu_a_sel;
        ctrl_pkg::alu_b_sel_t alu_b_sel;
        ctrl_pkg::mem_r_sel_t mem_r_sel;
        ctrl_pkg::mem_mask_t mem_mask;
        ctrl_pkg::reg_w_sel_t reg_w_sel;
        logic ebreak_flag, reg_wen, mem_wen, mem_ren;
        exp_t pending[$];
        int cycles;

        clk_gen u_clk_gen (.clk(clk));

        control u_control (
                .clk(clk), .arst_n(arst_n), .inst(inst), .b_eq(b_eq), .b_lt(b_lt),
                .b_ltu(b_ltu), .pc_sel(pc_sel), .ebreak_flag(ebreak_flag),
                .imm_sel(imm_sel), .alu_sel(alu_sel), .alu_a_sel(alu_a_sel),
                .alu_b_sel(alu_b_sel), .mem_r_sel(mem_r_sel), .reg_wen(reg_wen),
                .mem_wen(mem_wen), .mem_ren(mem_ren), .mem_mask(mem_mask),
                .reg_w_sel(reg_w_sel)
        );

        task automatic stop_on_error(string name, logic [7:0] got, logic [7:0] want);
                $display("** Error: %s got 0x%h expected 0x%h", name, got, want);
                $display("RESULT: FAIL");
                $fatal(1, "mismatch on %s", name);
        endtask

        task automatic alu_compare(ctrl_pkg::alu_sel_t got, ctrl_pkg::alu_sel_t want);
                if (got !== want) stop_on_error("alu_sel", 8'(got), 8'(want));
        endtask

        task automatic imm_compare(ctrl_pkg::imm_sel_t got, ctrl_pkg::imm_sel_t want);
                if (got !== want) stop_on_error("imm_sel", 8'(got), 8'(want));
        endtask

        // 2 and 3 bit selects
        task automatic sel_compare(string name, logic [2:0] got, logic [2:0] want);
                if (got !== want) stop_on_error(name, 8'(got), 8'(want));
        endtask

        task automatic mask_compare(ctrl_pkg::mem_mask_t got, ctrl_pkg::mem_mask_t want);
                if (got !== want) stop_on_error("mem_mask", got, want);
        endtask

        task automatic bit_compare(string name, logic got, logic want);
                if (got !== want) stop_on_error(name, 8'(got), 8'(want));
        endtask

        task automatic compare_outputs(exp_t e);
                alu_compare(alu_sel, e.alu);
                imm_compare(imm_sel, e.imm);
                sel_compare("alu_a_sel", 3'(alu_a_sel), 3'(e.a));
                sel_compare("mem_r_sel", mem_r_sel, e.r);
                sel_compare("reg_w_sel", 3'(reg_w_sel), 3'(e.w));
                mask_compare(mem_mask, e.mask);
                bit_compare("alu_b_sel", alu_b_sel, e.b);
                bit_compare("pc_sel", pc_sel, e.pc);
                bit_compare("ebreak_flag", ebreak_flag, e.ebreak);
                bit_compare("reg_wen", reg_wen, e.reg_wen);
                bit_compare("mem_wen", mem_wen, e.mem_wen);
                bit_compare("mem_ren", mem_ren, e.mem_ren);
        endtask

        function automatic exp_t model(isa_pkg::inst_t w, logic eq, logic lt, logic ltu);
                exp_t e;
                logic [2:0] f3;
                logic [6:0] f7;
                logic ok;
                e  = '0;
                f3 = w[14:12];
                f7 = w[31:25];
                ok = 1'b1;
                case (w[6:0])
                7'b0110011: begin // register ops
                        if (f7 == 7'h20 && f3 == 3'd0) e.alu = 5'd1;
                        else if (f7 == 7'h20 && f3 == 3'd5) e.alu = 5'd7;
                        else if (f7 != 7'h00) ok = 1'b0;
                        else case (f3)
                                3'd0: e.alu = 5'd0;
                                3'd1: e.alu = 5'd5;
                                3'd2: e.alu = 5'd8;
                                3'd3: e.alu = 5'd9;
                                3'd4: e.alu = 5'd4;
                                3'd5: e.alu = 5'd6;
                                3'd6: e.alu = 5'd3;
                                default: e.alu = 5'd2;
                        endcase
                end
                7'b0111011: begin
                        if (f7 == 7'h00 && f3 == 3'd0) e.alu = 5'd10;
                        else if (f7 == 7'h20 && f3 == 3'd0) e.alu = 5'd11;
                        else if (f7 == 7'h00 && f3 == 3'd1) e.alu = 5'd12;
                        else if (f7 == 7'h00 && f3 == 3'd5) e.alu = 5'd13;
                        else if (f7 == 7'h20 && f3 == 3'd5) e.alu = 5'd14;
                        else ok = 1'b0;
                end
                7'b0010011: begin
                        e.b = 1'b1;
                        case (f3)
                        3'd0: e.alu = 5'd0;
                        3'd1: begin
                                e.alu = 5'd5;
                                ok = f7[6:1] == 6'h00; // shamt[5] free
                        end
                        3'd2: e.alu = 5'd8;
                        3'd3: e.alu = 5'd9;
                        3'd4: e.alu = 5'd4;
                        3'd5: begin
                                if (f7[6:1] == 6'h00) e.alu = 5'd6;
                                else if (f7[6:1] == 6'h10) e.alu = 5'd7;
                                else ok = 1'b0;
                        end
                        3'd6: e.alu = 5'd3;
                        default: e.alu = 5'd2;
                        endcase
                end
                7'b0011011: begin
                        e.b = 1'b1;
                        if (f3 == 3'd0) e.alu = 5'd10;
                        else if (f7 == 7'h00 && f3 == 3'd1) e.alu = 5'd12;
                        else if (f7 == 7'h00 && f3 == 3'd5) e.alu = 5'd13;
                        else if (f7 == 7'h20 && f3 == 3'd5) e.alu = 5'd14;
                        else ok = 1'b0;
                end
                7'b0010111: begin // auipc
                        e.b = 1'b1;
                        e.a = 2'd1;
                        e.imm = 3'd3;
                end
                7'b0110111: begin // lui
                        e.b = 1'b1;
                        e.a = 2'd2;
                        e.imm = 3'd3;
                end
                7'b0000011: begin
                        ok = f3 != 3'd7;
                        e.b = 1'b1;
                        e.mem_ren = 1'b1;
                        e.r = f3;
                        e.w = 2'd1;
                end
                7'b0100011: begin
                        ok = !f3[2];
                        e.b = 1'b1;
                        e.mem_wen = 1'b1;
                        e.imm = 3'd1;
                        e.mask = 8'((16'h1 << (1 << f3[1:0])) - 1);
                end
                7'b1100011: begin
                        ok = f3 != 3'd2 && f3 != 3'd3;
                        e.b = 1'b1;
                        e.a = 2'd1;
                        e.imm = 3'd2;
                        case (f3)
                        3'd0: e.pc = eq;
                        3'd1: e.pc = !eq;
                        3'd4: e.pc = lt;
                        3'd5: e.pc = !lt;
                        3'd6: e.pc = ltu;
                        default: e.pc = !ltu;
                        endcase
                end
                7'b1101111: begin // jal
                        e.b = 1'b1;
                        e.a = 2'd1;
                        e.imm = 3'd4;
                        e.pc = 1'b1;
                        e.w = 2'd2;
                end
                7'b1100111: begin // jalr
                        ok = f3 == 3'd0;
                        e.b = 1'b1;
                        e.pc = 1'b1;
                        e.w = 2'd2;
                end
                default: ok = 1'b0;
                endcase
                e.reg_wen = !e.mem_wen && !(w[6:0] == 7'b1100011);
                if (w == 32'h0010_0073 || !ok) begin
                        e = '0;
                        e.ebreak = 1'b1;
                end
                return e;
        endfunction

        function automatic isa_pkg::inst_t random_inst();
                isa_pkg::inst_t w;
                logic [6:0] ops[12];
                logic alt;
                ops = '{7'h33, 7'h3b, 7'h13, 7'h1b, 7'h03, 7'h23,
                        7'h63, 7'h6f, 7'h67, 7'h17, 7'h37, 7'h73};
                w   = $urandom;
                alt = 1'($urandom_range(0, 1));
                if ($urandom_range(0, 9) == 0)
                        return w; // fully random word
                w[6:0] = ops[$urandom_range(0, 11)];
                case (w[6:0])
                7'h33, 7'h3b, 7'h1b: w[31:25] = alt ? 7'h20 : 7'h00;
                7'h13: if (w[13:12] == 2'b01) w[31:26] = alt ? 6'h10 : 6'h00;
                7'h03: w[14:12] = 3'($urandom_range(0, 6));
                7'h23: w[14:12] = 3'($urandom_range(0, 3));
                7'h67: w[14:12] = 3'd0;
                7'h73: w = isa_pkg::inst_ebreak;
                default: ;
                endcase
                return w;
        endfunction

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= max_cycle) begin
                        $display("timeout after %0d cycles", cycles);
                        $display("RESULT: FAIL");
                        $fatal(1, "run did not finish");
                end
        end

        initial begin
                void'($urandom(32'hbecf_a21e));
                cycles = 0;
                arst_n = 1'b0;
                inst   = '0;
                b_eq   = 1'b0;
                b_lt   = 1'b0;
                b_ltu  = 1'b0;
                repeat (rst_cyc) @(posedge clk);
                @(negedge clk);
                arst_n = 1'b1;
                #1;
                compare_outputs('0); // before the first rising edge
                for (int i = 0; i <= num_inst; i++) begin
                        @(negedge clk);
                        if (pending.size() > 0) compare_outputs(pending.pop_front());
                        if (i < num_inst) begin
                                inst  = random_inst();
                                b_eq  = 1'($urandom_range(0, 1));
                                b_lt  = 1'($urandom_range(0, 1));
                                b_ltu = 1'($urandom_range(0, 1));
                                pending.push_back(model(inst, b_eq, b_lt, b_ltu));
                        end
                end
                $display("RESULT: PASS");
                $finish;
        end

endmodule

// File: src.f
source/isa_pkg.sv
source/ctrl_pkg.sv
source/alu_decode.sv
source/mem_decode.sv
source/flow_decode.sv
source/control.sv
sim/clk_gen.sv
sim/control_props.sv
sim/control_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = control_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
